// File: rtl/ncsi_csr_pkg.sv
/*
 * Shared types and constants for the NC-SI control and status register block.
 * Register offsets are word addresses (byte offset / 4) on the Wishbone port.
 * Referenced with scoped names throughout the design.
 */
package ncsi_csr_pkg;

   //------------------------------------------------------------
   // Word types
   //------------------------------------------------------------
   localparam logic [4:0] NUM_CH = 5'd1;          // Channels supported

   typedef logic [31:0]       csr_word_t;
   typedef logic [7:0]        csr_addr_t;
   typedef logic [NUM_CH-1:0] ch_mask_t;
   typedef logic [2:0]        pkg_id_t;
   typedef logic [11:0]       resp_size_t;
   typedef logic [15:0]       cmd_err_t;
   typedef logic [5:0]        t5_count_t;
   typedef logic [10:0]       t6_count_t;

   //------------------------------------------------------------
   // Capability constants
   //------------------------------------------------------------
   localparam logic [3:0]  CAP_NUM_UNIMAC    = 4'h1;
   localparam logic [3:0]  CAP_NUM_MULMAC    = 4'h0;
   localparam logic [3:0]  CAP_NUM_MIXMAC    = 4'h0;
   localparam logic [3:0]  CAP_NUM_VLAN      = 4'h1;
   localparam logic [2:0]  CAP_VLAN_MODE     = 3'h7;
   localparam logic        CAP_ALL_MCAST     = 1'b0;
   localparam logic [15:0] CAP_BCAST_FILTERS = 16'h1;
   localparam logic [15:0] CAP_MCAST_FILTERS = 16'h0;
   localparam logic [15:0] IPT_BUFR_DEPTH    = 16'd8192;
   localparam logic [7:0]  MAX_FC_REQ        = 8'd16;

   localparam csr_word_t CAP0_WORD = {CAP_ALL_MCAST, 4'h0, CAP_VLAN_MODE, CAP_NUM_VLAN,
                                      CAP_NUM_MIXMAC, CAP_NUM_MULMAC, CAP_NUM_UNIMAC,
                                      3'h0, NUM_CH};
   localparam csr_word_t CAP1_WORD = {CAP_MCAST_FILTERS, CAP_BCAST_FILTERS};
   localparam csr_word_t CAP2_WORD = {MAX_FC_REQ, 8'h0, IPT_BUFR_DEPTH};

   // Millisecond timer limits
   localparam t5_count_t T5_LIMIT = 6'd40;        // ~40 ms
   localparam t6_count_t T6_LIMIT = 11'd1900;     // ~1.9 s

   localparam csr_word_t BAD_ADDR_DATA = 32'hDEADBEEF;

   //------------------------------------------------------------
   // Word offsets
   //------------------------------------------------------------
   localparam csr_addr_t ADDR_CAP0     = 8'h00;
   localparam csr_addr_t ADDR_CAP1     = 8'h01;
   localparam csr_addr_t ADDR_CAP2     = 8'h02;
   localparam csr_addr_t ADDR_RX_CMD   = 8'h20;
   localparam csr_addr_t ADDR_TX_RESP  = 8'h28;
   localparam csr_addr_t ADDR_GEN_CTRL = 8'h30;
   localparam csr_addr_t ADDR_CH_EN    = 8'h31;
   localparam csr_addr_t ADDR_PTNW_EN  = 8'h32;
   localparam csr_addr_t ADDR_INIT_ST  = 8'h33;
   localparam csr_addr_t ADDR_INTR     = 8'h3C;

endpackage

// File: rtl/ncsi_reg_access_if.sv
/*
 * Internal register-access channel. The bus front end issues one-cycle
 * read/write strobes, the register file answers with combinational read data
 * and the event block snoops the writes.
 */
`timescale 1ns/1ps

interface ncsi_reg_access_if;

   logic                     acc_wr;        // One-cycle write strobe
   logic                     acc_rd;        // One-cycle read strobe
   ncsi_csr_pkg::csr_addr_t  acc_addr;
   ncsi_csr_pkg::csr_word_t  acc_wdata;
   ncsi_csr_pkg::csr_word_t  acc_rdata;     // Valid during acc_rd

   modport bus (
      output acc_wr, acc_rd, acc_addr, acc_wdata,
      input  acc_rdata
   );

   modport regs (
      input  acc_wr, acc_addr, acc_wdata,
      output acc_rdata
   );

   // Write snooping only
   modport monitor (
      input  acc_wr, acc_addr, acc_wdata
   );

endinterface

// File: rtl/ncsi_wb_slave.sv
/*
 * Wishbone classic slave front end. Each new cycle becomes a single-cycle
 * access strobe; ack and read data are registered one cycle later.
 */
`timescale 1ns/1ps

module ncsi_wb_slave (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  ncsi_csr_pkg::csr_addr_t  wb_adr_i,
   input  ncsi_csr_pkg::csr_word_t  wb_dat_i,
   output ncsi_csr_pkg::csr_word_t  wb_dat_o,
   output logic                     wb_ack_o,
   ncsi_reg_access_if.bus           acc
);

   logic new_req;

   // New request only while ack is low, so a held request is taken once
   assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   assign acc.acc_wr    = new_req & wb_we_i;
   assign acc.acc_rd    = new_req & ~wb_we_i;
   assign acc.acc_addr  = wb_adr_i;
   assign acc.acc_wdata = wb_dat_i;

   //------------------------------------------------------------
   // Ack and read data
   //------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
      end else begin
         wb_ack_o <= new_req;                 // Single-cycle ack without stall
         if (acc.acc_rd)
            wb_dat_o <= acc.acc_rdata;        // Held between reads
      end
   end

endmodule

// File: rtl/ncsi_ctrl_regs.sv
/*
 * Control register file: transmit-response, general control and channel
 * masks. Also owns the full read multiplexer, including the capability words
 * and the interrupt image supplied by the event/timer block.
 */
`timescale 1ns/1ps

module ncsi_ctrl_regs (
   input  logic                        clk,
   input  logic                        reset,
   ncsi_reg_access_if.regs             acc,

   input  ncsi_csr_pkg::csr_word_t     intr_word_i,
   input  logic                        cmd_rx_sts_i,
   input  ncsi_csr_pkg::resp_size_t    rx_cmd_size_i,
   input  ncsi_csr_pkg::cmd_err_t      rx_cmd_err_i,
   input  logic                        tx_resp_sent_i,

   output logic                        tx_resp_avail_o,
   output logic                        tx_resp_naen_o,
   output ncsi_csr_pkg::resp_size_t    tx_resp_size_o,
   output logic                        tx_eb4sr_o,
   output logic                        package_en_o,
   output logic                        ignr_fltr_cfg_o,
   output ncsi_csr_pkg::pkg_id_t       package_id_o,
   output logic                        eptb_reset_o,
   output logic                        iptb_reset_o,
   output ncsi_csr_pkg::ch_mask_t      ch_en_o,
   output ncsi_csr_pkg::ch_mask_t      ptnw_tx_en_o,
   output ncsi_csr_pkg::ch_mask_t      ch_init_st_o
);

   logic wr_tx_resp;
   logic wr_gen_ctrl;
   logic wr_ch_en;
   logic wr_ptnw_en;
   logic wr_init_st;

   assign wr_tx_resp  = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_TX_RESP);
   assign wr_gen_ctrl = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_GEN_CTRL);
   assign wr_ch_en    = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_CH_EN);
   assign wr_ptnw_en  = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_PTNW_EN);
   assign wr_init_st  = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_INIT_ST);

   //------------------------------------------------------------
   // Writeable registers
   //------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         tx_resp_avail_o <= 1'b0;
         tx_resp_naen_o  <= 1'b0;
         tx_resp_size_o  <= '0;
         tx_eb4sr_o      <= 1'b0;
         package_en_o    <= 1'b0;
         ignr_fltr_cfg_o <= 1'b0;
         package_id_o    <= '0;
         eptb_reset_o    <= 1'b0;
         iptb_reset_o    <= 1'b0;
         ch_en_o         <= '0;
         ptnw_tx_en_o    <= '0;
         ch_init_st_o    <= '0;
      end else begin
         // A write beats the response-sent self clear
         if (wr_tx_resp) begin
            tx_resp_avail_o <= acc.acc_wdata[0];
            tx_resp_naen_o  <= acc.acc_wdata[1];
            tx_resp_size_o  <= acc.acc_wdata[15:4];
            tx_eb4sr_o      <= acc.acc_wdata[16];
         end else if (tx_resp_sent_i) begin
            tx_resp_avail_o <= 1'b0;            // Response gone out
         end

         if (wr_gen_ctrl) begin
            package_en_o    <= acc.acc_wdata[0];
            ignr_fltr_cfg_o <= acc.acc_wdata[1];
            package_id_o    <= acc.acc_wdata[10:8];
            eptb_reset_o    <= acc.acc_wdata[30];
            iptb_reset_o    <= acc.acc_wdata[31];
         end

         // Per-channel masks
         if (wr_ch_en)
            ch_en_o <= acc.acc_wdata[ncsi_csr_pkg::NUM_CH-1:0];
         if (wr_ptnw_en)
            ptnw_tx_en_o <= acc.acc_wdata[ncsi_csr_pkg::NUM_CH-1:0];
         if (wr_init_st)
            ch_init_st_o <= acc.acc_wdata[ncsi_csr_pkg::NUM_CH-1:0];
      end
   end

   //------------------------------------------------------------
   // Read multiplexer
   //------------------------------------------------------------
   always_comb begin
      case (acc.acc_addr)
         ncsi_csr_pkg::ADDR_CAP0     : acc.acc_rdata = ncsi_csr_pkg::CAP0_WORD;
         ncsi_csr_pkg::ADDR_CAP1     : acc.acc_rdata = ncsi_csr_pkg::CAP1_WORD;
         ncsi_csr_pkg::ADDR_CAP2     : acc.acc_rdata = ncsi_csr_pkg::CAP2_WORD;
         ncsi_csr_pkg::ADDR_RX_CMD   :
            acc.acc_rdata = {rx_cmd_err_i, rx_cmd_size_i, 3'b000, cmd_rx_sts_i};
         ncsi_csr_pkg::ADDR_TX_RESP  :
            acc.acc_rdata = {15'h0, tx_eb4sr_o, tx_resp_size_o, 2'b00,
                             tx_resp_naen_o, tx_resp_avail_o};
         ncsi_csr_pkg::ADDR_GEN_CTRL :
            acc.acc_rdata = {iptb_reset_o, eptb_reset_o, 19'h0, package_id_o, 6'h0,
                             ignr_fltr_cfg_o, package_en_o};
         ncsi_csr_pkg::ADDR_CH_EN    : acc.acc_rdata = ncsi_csr_pkg::csr_word_t'(ch_en_o);
         ncsi_csr_pkg::ADDR_PTNW_EN  : acc.acc_rdata = ncsi_csr_pkg::csr_word_t'(ptnw_tx_en_o);
         ncsi_csr_pkg::ADDR_INIT_ST  : acc.acc_rdata = ncsi_csr_pkg::csr_word_t'(ch_init_st_o);
         ncsi_csr_pkg::ADDR_INTR     : acc.acc_rdata = intr_word_i;  // Built by event block
         default                     : acc.acc_rdata = ncsi_csr_pkg::BAD_ADDR_DATA;
      endcase
   end

endmodule

// File: rtl/ncsi_event_timers.sv
/*
 * Interrupt status/enable bits and the T5/T6 millisecond timers. Snoops
 * writes to the interrupt register and drives the combined interrupt output.
 */
`timescale 1ns/1ps

module ncsi_event_timers (
   input  logic                     clk,
   input  logic                     reset,
   ncsi_reg_access_if.monitor       acc,

   input  logic                     pulse_1ms_i,
   input  logic                     rx_cmd_pulse_i,
   input  ncsi_csr_pkg::cmd_err_t   rx_cmd_err_i,
   input  logic                     daemon_up_i,
   input  logic                     rbt_clk_prsnt_i,

   output ncsi_csr_pkg::csr_word_t  intr_word_o,
   output logic                     cmd_rx_sts_o,
   output logic                     rx_cmd_busy_o,
   output logic                     ncsi_intr_o
);

   logic                      intr_wr;
   logic                      cmd_ok;
   logic                      daemon_up_r1;
   logic [3:0]                intr_evt;
   logic [3:0]                intr_clr;
   logic [3:0]                intr_sts;      // Cmd, T5, T6, heartbeat
   logic [3:0]                intr_en;

   logic                      t5_en;
   ncsi_csr_pkg::t5_count_t   t5_cnt;
   logic                      t5_expr;
   logic                      t6_en;
   ncsi_csr_pkg::t6_count_t   t6_cnt;
   logic                      t6_expr;

   assign intr_wr = acc.acc_wr && (acc.acc_addr == ncsi_csr_pkg::ADDR_INTR);

   // Only a buffer overflow (err[0]) is tolerated
   assign cmd_ok = rx_cmd_pulse_i && (rx_cmd_err_i[5:1] == 5'd0);

   assign intr_evt = {daemon_up_i & ~daemon_up_r1, t6_expr, t5_expr, cmd_ok};
   assign intr_clr = intr_wr ? acc.acc_wdata[3:0] : 4'h0;

   //------------------------------------------------------------
   // Status and enable
   //------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         daemon_up_r1 <= 1'b0;
         intr_sts     <= '0;
         intr_en      <= '0;
      end else begin
         daemon_up_r1 <= daemon_up_i;
         intr_sts     <= intr_evt | (intr_sts & ~intr_clr);   // Event wins over W1C
         if (intr_wr)
            intr_en <= acc.acc_wdata[27:24];
      end
   end

   //------------------------------------------------------------
   // T5 and T6 timers
   //------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         t5_en   <= 1'b0;
         t5_cnt  <= '0;
         t5_expr <= 1'b0;
         t6_en   <= 1'b0;
         t6_cnt  <= '0;
         t6_expr <= 1'b0;
      end else begin
         // T5 armed by an accepted command
         if (t5_expr || (intr_wr && acc.acc_wdata[9]))
            t5_en <= 1'b0;
         else if (cmd_ok)
            t5_en <= 1'b1;

         if (!t5_en)
            t5_cnt <= '0;
         else if (pulse_1ms_i)
            t5_cnt <= t5_cnt + 1'b1;

         t5_expr <= t5_en && pulse_1ms_i && (t5_cnt == ncsi_csr_pkg::T5_LIMIT);

         // T6 started by firmware
         if (t6_expr || (intr_wr && acc.acc_wdata[10]))
            t6_en <= 1'b0;
         else if (intr_wr && acc.acc_wdata[18])
            t6_en <= 1'b1;

         if (!t6_en)
            t6_cnt <= '0;
         else if (pulse_1ms_i)
            t6_cnt <= t6_cnt + 1'b1;

         t6_expr <= t6_en && pulse_1ms_i && (t6_cnt == ncsi_csr_pkg::T6_LIMIT);
      end
   end

   // Stop bits read back as zero
   assign intr_word_o = {4'h0, intr_en, 5'h0, t6_en, 13'h0, rbt_clk_prsnt_i, intr_sts};

   assign cmd_rx_sts_o  = intr_sts[0];
   assign rx_cmd_busy_o = intr_sts[0];
   assign ncsi_intr_o   = |(intr_sts & intr_en);

endmodule

// File: rtl/ncsi_csr_top.sv
/*
 * NC-SI sideband CSR block top level. Plain Wishbone classic slave ports
 * towards the management processor; wires front end, registers and timers.
 */
`timescale 1ns/1ps

module ncsi_csr_top (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        pulse_1ms_i,

   // Wishbone classic slave
   input  logic                        wb_cyc_i,
   input  logic                        wb_stb_i,
   input  logic                        wb_we_i,
   input  ncsi_csr_pkg::csr_addr_t     wb_adr_i,
   input  ncsi_csr_pkg::csr_word_t     wb_dat_i,
   output ncsi_csr_pkg::csr_word_t     wb_dat_o,
   output logic                        wb_ack_o,

   // Sideband controller status
   input  logic                        rbt_clk_prsnt_i,
   input  logic                        daemon_up_i,
   input  logic                        rx_cmd_pulse_i,
   input  ncsi_csr_pkg::resp_size_t    rx_cmd_size_i,
   input  ncsi_csr_pkg::cmd_err_t      rx_cmd_err_i,
   output logic                        rx_cmd_busy_o,
   input  logic                        tx_resp_sent_i,
   output logic                        ncsi_intr_o,

   // Control outputs
   output logic                        tx_resp_avail_o,
   output logic                        tx_resp_naen_o,
   output ncsi_csr_pkg::resp_size_t    tx_resp_size_o,
   output logic                        tx_eb4sr_o,
   output logic                        package_en_o,
   output logic                        ignr_fltr_cfg_o,
   output ncsi_csr_pkg::pkg_id_t       package_id_o,
   output logic                        eptb_reset_o,
   output logic                        iptb_reset_o,
   output ncsi_csr_pkg::ch_mask_t      ch_en_o,
   output ncsi_csr_pkg::ch_mask_t      ptnw_tx_en_o,
   output ncsi_csr_pkg::ch_mask_t      ch_init_st_o
);

   ncsi_csr_pkg::csr_word_t intr_word;
   logic                    cmd_rx_sts;

   ncsi_reg_access_if acc_if ();

   ncsi_wb_slave u_wb_slave (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .acc      (acc_if.bus)
   );

   ncsi_ctrl_regs u_ctrl_regs (
      .clk             (clk),
      .reset           (reset),
      .acc             (acc_if.regs),
      .intr_word_i     (intr_word),
      .cmd_rx_sts_i    (cmd_rx_sts),
      .rx_cmd_size_i   (rx_cmd_size_i),
      .rx_cmd_err_i    (rx_cmd_err_i),
      .tx_resp_sent_i  (tx_resp_sent_i),
      .tx_resp_avail_o (tx_resp_avail_o),
      .tx_resp_naen_o  (tx_resp_naen_o),
      .tx_resp_size_o  (tx_resp_size_o),
      .tx_eb4sr_o      (tx_eb4sr_o),
      .package_en_o    (package_en_o),
      .ignr_fltr_cfg_o (ignr_fltr_cfg_o),
      .package_id_o    (package_id_o),
      .eptb_reset_o    (eptb_reset_o),
      .iptb_reset_o    (iptb_reset_o),
      .ch_en_o         (ch_en_o),
      .ptnw_tx_en_o    (ptnw_tx_en_o),
      .ch_init_st_o    (ch_init_st_o)
   );

   ncsi_event_timers u_event_timers (
      .clk             (clk),
      .reset           (reset),
      .acc             (acc_if.monitor),
      .pulse_1ms_i     (pulse_1ms_i),
      .rx_cmd_pulse_i  (rx_cmd_pulse_i),
      .rx_cmd_err_i    (rx_cmd_err_i),
      .daemon_up_i     (daemon_up_i),
      .rbt_clk_prsnt_i (rbt_clk_prsnt_i),
      .intr_word_o     (intr_word),
      .cmd_rx_sts_o    (cmd_rx_sts),
      .rx_cmd_busy_o   (rx_cmd_busy_o),
      .ncsi_intr_o     (ncsi_intr_o)
   );

endmodule

// File: sim/ncsi_csr_checker.sv
/*
 * Bus handshake and interrupt output assertions, bound to the CSR top level.
 */
`timescale 1ns/1ps

module ncsi_csr_checker (
   input logic       clk,
   input logic       reset,
   input logic       wb_cyc_i,
   input logic       wb_stb_i,
   input logic       wb_ack_o,
   input logic       ncsi_intr_o,
   input logic [3:0] intr_en
);

   // Ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
      wb_ack_o |=> !wb_ack_o)
      else $error("ack held longer than one cycle");

   ack_after_stb: assert property (@(posedge clk) disable iff (reset)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
      else $error("ack without a preceding request");

   // Masked interrupt must stay quiet
   intr_masked: assert property (@(posedge clk) disable iff (reset)
      (intr_en == 4'h0) |-> !ncsi_intr_o)
      else $error("interrupt raised with all enables off");

endmodule

// File: sim/ncsi_csr_tb.sv
/*
 * Table-driven testbench for the NC-SI CSR block. Drives Wishbone cycles
 * on the falling edge and checks registers, outputs, events and timers.
 */
`timescale 1ns/1ps

module ncsi_csr_tb;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic pulse_1ms_i = 0, wb_cyc_i = 0, wb_stb_i = 0, wb_we_i = 0;
   ncsi_csr_pkg::csr_addr_t wb_adr_i = '0;
   ncsi_csr_pkg::csr_word_t wb_dat_i = '0, wb_dat_o;
   ncsi_csr_pkg::csr_word_t rd;                  // Data of the last bus cycle
   logic wb_ack_o, rbt_clk_prsnt_i = 0, daemon_up_i = 0, rx_cmd_pulse_i = 0;
   ncsi_csr_pkg::resp_size_t rx_cmd_size_i = 12'h05A;
   ncsi_csr_pkg::cmd_err_t rx_cmd_err_i = '0;
   logic rx_cmd_busy_o, tx_resp_sent_i = 0, ncsi_intr_o;
   logic tx_resp_avail_o, tx_resp_naen_o, tx_eb4sr_o, package_en_o, ignr_fltr_cfg_o;
   logic eptb_reset_o, iptb_reset_o;
   ncsi_csr_pkg::resp_size_t tx_resp_size_o;
   ncsi_csr_pkg::pkg_id_t package_id_o;
   ncsi_csr_pkg::ch_mask_t ch_en_o, ptnw_tx_en_o, ch_init_st_o;
   int errors = 0, tests = 0, test_err = 0;

   // Stimulus table of address, write data and readback mask
   ncsi_csr_pkg::csr_addr_t tbl_addr [6] = '{8'h28, 8'h30, 8'h31, 8'h32, 8'h33, 8'h30};
   ncsi_csr_pkg::csr_word_t tbl_wdata [6];
   ncsi_csr_pkg::csr_word_t tbl_mask [6] = '{32'h0001_FFF3, 32'hC000_0703, 32'h1,
                                            32'h1, 32'h1, 32'hC000_0703};

   always #50 clk = ~clk;

   ncsi_csr_top UUT (.*);

   bind ncsi_csr_top ncsi_csr_checker u_checker (
      .clk(clk), .reset(reset), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_ack_o(wb_ack_o), .ncsi_intr_o(ncsi_intr_o), .intr_en(u_event_timers.intr_en));

   task automatic timeout_fail(input string what);
      $display("Timeout waiting for %s at %0t", what, $time);
      $display("Something failed");
      $finish;
   endtask

   task automatic check_word(input string name, input ncsi_csr_pkg::csr_word_t got,
                             input ncsi_csr_pkg::csr_word_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_mask(input string name, input ncsi_csr_pkg::ch_mask_t got,
                             input ncsi_csr_pkg::ch_mask_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == test_err) ? "pass" : "FAIL");
      test_err = errors;
   endtask

   // Bus cycle held until ack is seen at a falling edge
   task automatic bus_cycle(input logic we, input ncsi_csr_pkg::csr_addr_t addr,
                            input ncsi_csr_pkg::csr_word_t data);
      int n;
      @(negedge clk);
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {2'b11, we, addr, data};
      for (n = 0; n < 10 && !wb_ack_o; n++)
         @(negedge clk);
      if (!wb_ack_o)
         timeout_fail("wb_ack_o");
      rd = wb_dat_o;
      {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
   endtask

   task automatic bus_write(input ncsi_csr_pkg::csr_addr_t a, input ncsi_csr_pkg::csr_word_t d);
      bus_cycle(1'b1, a, d);
   endtask

   task automatic bus_read(input ncsi_csr_pkg::csr_addr_t a);
      bus_cycle(1'b0, a, '0);
   endtask

   task automatic pulse_cmd(input ncsi_csr_pkg::cmd_err_t err);
      @(negedge clk);
      {rx_cmd_pulse_i, rx_cmd_err_i} = {1'b1, err};
      @(negedge clk);
      rx_cmd_pulse_i = 1'b0;
   endtask

   // Millisecond ticks until the interrupt rises
   task automatic tick_until_intr(input int max_ticks, input string what);
      int n;
      for (n = 0; n < max_ticks && !ncsi_intr_o; n++) begin
         @(negedge clk) pulse_1ms_i = 1'b1;
         @(negedge clk) pulse_1ms_i = 1'b0;
         repeat (2) @(negedge clk);
      end
      if (!ncsi_intr_o)
         timeout_fail(what);
   endtask

   initial begin
      int i, k;
      ncsi_csr_pkg::csr_word_t d;
      tbl_wdata[0] = $urandom(8);                // First draw also seeds the generator
      for (i = 1; i < 6; i++)
         tbl_wdata[i] = $urandom();
      repeat (2) @(negedge clk);
      reset = 1'b0;

      //------------------------------------------------------------
      // Capability words and unmapped read
      //------------------------------------------------------------
      bus_read(8'h00);
      check_word("cap0 wb_dat_o", rd, {1'b0, 4'h0, 3'h7, 4'h1, 8'h0, 4'h1, 8'h01});
      bus_read(8'h01);
      check_word("cap1 wb_dat_o", rd, 32'h0000_0001);
      bus_read(8'h02);
      check_word("cap2 wb_dat_o", rd, 32'h1000_2000);
      bus_read(8'h10);
      check_word("unmapped wb_dat_o", rd, 32'hDEADBEEF);
      end_test("capability");

      for (i = 0; i < 6; i++) begin
         for (k = 0; k < 2; k++) begin
            d = (k == 0) ? tbl_wdata[i] : ~tbl_wdata[i];   // Each bit both ways
            bus_write(tbl_addr[i], d);
            bus_read(tbl_addr[i]);
            check_word("readback wb_dat_o", rd, d & tbl_mask[i]);
            case (tbl_addr[i])
               8'h28: begin
                  check_bit("tx_resp_avail_o", tx_resp_avail_o, d[0]);
                  check_bit("tx_resp_naen_o", tx_resp_naen_o, d[1]);
                  check_word("tx_resp_size_o", {20'h0, tx_resp_size_o}, {20'h0, d[15:4]});
                  check_bit("tx_eb4sr_o", tx_eb4sr_o, d[16]);
               end
               8'h30: begin
                  check_bit("package_en_o", package_en_o, d[0]);
                  check_bit("ignr_fltr_cfg_o", ignr_fltr_cfg_o, d[1]);
                  check_word("package_id_o", {29'h0, package_id_o}, {29'h0, d[10:8]});
                  check_bit("eptb_reset_o", eptb_reset_o, d[30]);
                  check_bit("iptb_reset_o", iptb_reset_o, d[31]);
               end
               8'h31: check_mask("ch_en_o", ch_en_o, d[0]);
               8'h32: check_mask("ptnw_tx_en_o", ptnw_tx_en_o, d[0]);
               default: check_mask("ch_init_st_o", ch_init_st_o, d[0]);
            endcase
         end
      end
      end_test("register table");

      // Sent response clears the available flag
      bus_write(8'h28, 32'h1);
      check_bit("tx_resp_avail_o", tx_resp_avail_o, 1'b1);
      @(negedge clk) tx_resp_sent_i = 1'b1;
      @(negedge clk) tx_resp_sent_i = 1'b0;
      check_bit("tx_resp_avail_o", tx_resp_avail_o, 1'b0);
      bus_read(8'h28);
      check_bit("tx_resp readback bit0", rd[0], 1'b0);
      end_test("response sent");

      //------------------------------------------------------------
      // Command received, timers, heartbeat
      //------------------------------------------------------------
      pulse_cmd(16'h0004);
      check_bit("rx_cmd_busy_o", rx_cmd_busy_o, 1'b0);
      pulse_cmd(16'h0001);
      check_bit("rx_cmd_busy_o", rx_cmd_busy_o, 1'b1);
      bus_read(8'h3C);
      check_bit("intr bit0", rd[0], 1'b1);
      bus_read(8'h20);
      check_word("rx_cmd word", rd, {16'h0001, 12'h05A, 4'h1});
      bus_write(8'h3C, 32'h201);                 // Clear and stop T5
      check_bit("rx_cmd_busy_o", rx_cmd_busy_o, 1'b0);
      bus_read(8'h3C);
      check_bit("intr bit0 cleared", rd[0], 1'b0);
      end_test("rx command");

      bus_write(8'h3C, 32'h0200_0000);
      pulse_cmd(16'h0000);
      tick_until_intr(60, "T5 expiry");
      bus_read(8'h3C);
      check_word("intr T5", rd & 32'hF, 32'h3);
      bus_write(8'h3C, 32'h0404_000F);           // Clear, enable T6, start T6
      bus_read(8'h3C);
      check_bit("intr T6 running", rd[18], 1'b1);
      tick_until_intr(2000, "T6 expiry");
      bus_read(8'h3C);
      check_word("intr T6", rd & 32'h0004_001F, 32'h4);
      end_test("timers");

      bus_write(8'h3C, 32'hF);
      @(negedge clk);
      daemon_up_i = 1'b1;
      rbt_clk_prsnt_i = 1'b1;
      repeat (2) @(negedge clk);
      check_bit("ncsi_intr_o masked", ncsi_intr_o, 1'b0);
      bus_read(8'h3C);
      check_bit("intr bit3", rd[3], 1'b1);
      check_bit("intr bit4 rbt_clk_prsnt_i", rd[4], 1'b1);
      bus_write(8'h3C, 32'h0800_0000);
      check_bit("ncsi_intr_o", ncsi_intr_o, 1'b1);
      end_test("heartbeat");

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: ncsi_csr.f
rtl/ncsi_csr_pkg.sv
rtl/ncsi_reg_access_if.sv
rtl/ncsi_wb_slave.sv
rtl/ncsi_ctrl_regs.sv
rtl/ncsi_event_timers.sv
rtl/ncsi_csr_top.sv
sim/ncsi_csr_checker.sv
sim/ncsi_csr_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ncsi_csr_tb -Mdir obj_dir -f ncsi_csr.f
	./obj_dir/Vncsi_csr_tb | tee sim.log
	grep -q "Everything OK" sim.log
	! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log
